// File: Bender.yml
package:
  name: vec_unit

sources:
  - src/vec_pkg.sv
  - src/tile_counter.sv
  - src/vector_add.sv
  - src/vec_ctrl.sv
  - src/vec_regs.sv
  - src/vec_unit.sv
  - target: test
    files:
      - test/vec_unit_sva.sv
      - test/tb_vec_unit.sv

// File: src/tile_counter.sv
`timescale 1ns/1ps

module tile_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    // Sync clear wins over enable
    input  logic                           cnt_clr,
    input  logic                           cnt_en,
    output logic [vec_pkg::TILE_IDX_W-1:0] tile_idx,
    output logic                           last
);

    ////////////////////////////////////////
    // Index register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_idx <= '0;
        end else if (cnt_clr) begin
            tile_idx <= '0;
        end else if (cnt_en) begin
            // Wraps back to zero after the last tile
            if (last) begin
                tile_idx <= '0;
            end else begin
                tile_idx <= tile_idx + 1'b1;
            end
        end
    end

    // Final tile of the vector
    assign last = tile_idx == vec_pkg::TILE_IDX_W'(vec_pkg::TILES - 1);

endmodule

// File: src/vec_ctrl.sv
`timescale 1ns/1ps

module vec_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    // Start request from the register block
    input  logic             start_req,
    input  vec_pkg::vec_op_e req_op,
    // Counter interface
    input  logic             last,
    output logic             cnt_clr,
    output logic             cnt_en,
    // Datapath steering
    output logic             issue_valid,
    output vec_pkg::vec_op_e run_op,
    // Status
    output logic             busy,
    output logic             done,
    output logic             run_start
);

    vec_pkg::ctrl_state_e state;
    vec_pkg::ctrl_state_e state_nxt;
    logic                 accept;

    // Starts only count when idle
    assign accept = (state == vec_pkg::ST_IDLE) && start_req;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            vec_pkg::ST_IDLE: begin
                if (accept) begin
                    state_nxt = vec_pkg::ST_ISSUE;
                end
            end
            // One tile per cycle until the last index
            vec_pkg::ST_ISSUE: begin
                if (last) begin
                    state_nxt = vec_pkg::ST_DRAIN;
                end
            end
            // Final tile still in the adder
            vec_pkg::ST_DRAIN: state_nxt = vec_pkg::ST_IDLE;
            default:           state_nxt = vec_pkg::ST_IDLE;
        endcase
    end

    // State, busy, done and latched op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= vec_pkg::ST_IDLE;
            busy   <= 1'b0;
            done   <= 1'b0;
            run_op <= vec_pkg::OP_ADD;
        end else begin
            state <= state_nxt;
            busy  <= state_nxt != vec_pkg::ST_IDLE;
            if (accept) begin
                done   <= 1'b0;
                run_op <= req_op;
            end else if (state == vec_pkg::ST_DRAIN) begin
                done <= 1'b1;
            end
        end
    end

    // Counter restarts with every accepted run
    assign run_start   = accept;
    assign cnt_clr     = accept;
    assign issue_valid = state == vec_pkg::ST_ISSUE;
    assign cnt_en      = state == vec_pkg::ST_ISSUE;

endmodule

// File: src/vec_pkg.sv
package vec_pkg;

    ////////////////////////////////////////
    // Vector geometry
    ////////////////////////////////////////

    // Elements per vector
    localparam int VECTOR_LEN = 16;
    // Signed element width
    localparam int CELL_WIDTH = 8;
    // Elements handled per clock
    localparam int TILING     = 4;
    localparam int TILES      = VECTOR_LEN / TILING;
    localparam int TILE_IDX_W = $clog2(TILES);
    // One tile fills exactly one bus word
    localparam int TILE_BITS  = TILING * CELL_WIDTH;

    ////////////////////////////////////////
    // Wishbone side and register map
    ////////////////////////////////////////

    // Word address and data widths
    localparam int WB_AW = 4;
    localparam int WB_DW = 32;

    localparam logic [WB_AW-1:0] ADR_CTRL   = 4'd0;
    localparam logic [WB_AW-1:0] ADR_STATUS = 4'd1;
    // Tile banks, four words each
    localparam logic [WB_AW-1:0] ADR_A_BASE = 4'd4;
    localparam logic [WB_AW-1:0] ADR_B_BASE = 4'd8;
    localparam logic [WB_AW-1:0] ADR_R_BASE = 4'd12;

    // CTRL bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_OP_BIT    = 1;
    // STATUS bits
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_SAT_BIT   = 2;

    // Element-wise operation
    typedef enum logic {OP_ADD = 1'b0, OP_SUB = 1'b1} vec_op_e;
    // Run FSM states
    typedef enum logic [1:0] {ST_IDLE = 2'd0, ST_ISSUE = 2'd1, ST_DRAIN = 2'd2} ctrl_state_e;

endpackage

// File: src/vec_regs.sv
`timescale 1ns/1ps

module vec_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    // Wishbone classic slave
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [vec_pkg::WB_AW-1:0]      wb_adr,
    input  logic [vec_pkg::WB_DW-1:0]      wb_dat_w,
    output logic [vec_pkg::WB_DW-1:0]      wb_dat_r,
    output logic                           wb_ack,
    // Run control
    output logic                           start_req,
    output vec_pkg::vec_op_e               req_op,
    input  logic                           busy,
    input  logic                           done,
    input  logic                           run_start,
    // Operand fetch
    input  logic [vec_pkg::TILE_IDX_W-1:0] tile_idx,
    output logic [vec_pkg::TILE_BITS-1:0]  a_tile,
    output logic [vec_pkg::TILE_BITS-1:0]  b_tile,
    // Result write back
    input  logic                           out_valid,
    input  logic [vec_pkg::TILE_IDX_W-1:0] out_tile,
    input  logic [vec_pkg::TILE_BITS-1:0]  result_tile,
    input  logic                           out_sat
);

    logic                                          ack_held;
    logic                                          bus_wr;
    logic [vec_pkg::WB_AW-vec_pkg::TILE_IDX_W-1:0] bank_sel;
    logic [vec_pkg::TILE_IDX_W-1:0]                word_sel;
    logic                                          a_hit;
    logic                                          b_hit;
    logic                                          r_hit;
    logic                                          sat_flag;
    logic [vec_pkg::TILE_BITS-1:0]                 a_bank [vec_pkg::TILES];
    logic [vec_pkg::TILE_BITS-1:0]                 b_bank [vec_pkg::TILES];
    logic [vec_pkg::TILE_BITS-1:0]                 r_bank [vec_pkg::TILES];

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////

    // Ack one cycle after the strobe, then wait for stb to drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            ack_held <= 1'b0;
        end else begin
            wb_ack   <= wb_cyc && wb_stb && !wb_ack && !ack_held;
            ack_held <= wb_cyc && wb_stb && (ack_held || wb_ack);
        end
    end

    // Writes take effect in the ack cycle
    assign bus_wr = wb_ack && wb_cyc && wb_stb && wb_we;

    // Upper address bits pick the bank, lower ones the tile word
    assign bank_sel = wb_adr[vec_pkg::WB_AW-1:vec_pkg::TILE_IDX_W];
    assign word_sel = wb_adr[vec_pkg::TILE_IDX_W-1:0];
    assign a_hit = bank_sel == vec_pkg::ADR_A_BASE[vec_pkg::WB_AW-1:vec_pkg::TILE_IDX_W];
    assign b_hit = bank_sel == vec_pkg::ADR_B_BASE[vec_pkg::WB_AW-1:vec_pkg::TILE_IDX_W];
    assign r_hit = bank_sel == vec_pkg::ADR_R_BASE[vec_pkg::WB_AW-1:vec_pkg::TILE_IDX_W];

    // Start pulse towards the FSM, which drops it when busy
    assign start_req = bus_wr && (wb_adr == vec_pkg::ADR_CTRL)
                       && wb_dat_w[vec_pkg::CTRL_START_BIT];
    assign req_op    = vec_pkg::vec_op_e'(wb_dat_w[vec_pkg::CTRL_OP_BIT]);

    ////////////////////////////////////////
    // Tile banks
    ////////////////////////////////////////

    // Operand banks, host writes ignored during a run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vec_pkg::TILES; i++) begin
                a_bank[i] <= '0;
                b_bank[i] <= '0;
            end
        end else if (bus_wr && !busy) begin
            if (a_hit) begin
                a_bank[word_sel] <= wb_dat_w;
            end
            if (b_hit) begin
                b_bank[word_sel] <= wb_dat_w;
            end
        end
    end

    // Result bank only written by the datapath
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vec_pkg::TILES; i++) begin
                r_bank[i] <= '0;
            end
            sat_flag <= 1'b0;
        end else begin
            if (out_valid) begin
                r_bank[out_tile] <= result_tile;
            end
            // Sticky clip flag, fresh for every run
            if (run_start) begin
                sat_flag <= 1'b0;
            end else if (out_valid && out_sat) begin
                sat_flag <= 1'b1;
            end
        end
    end

    // Operands for the tile being issued
    assign a_tile = a_bank[tile_idx];
    assign b_tile = b_bank[tile_idx];

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        wb_dat_r = '0;
        if (wb_adr == vec_pkg::ADR_STATUS) begin
            wb_dat_r[vec_pkg::STAT_BUSY_BIT] = busy;
            wb_dat_r[vec_pkg::STAT_DONE_BIT] = done;
            wb_dat_r[vec_pkg::STAT_SAT_BIT]  = sat_flag;
        end else if (a_hit) begin
            wb_dat_r = a_bank[word_sel];
        end else if (b_hit) begin
            wb_dat_r = b_bank[word_sel];
        end else if (r_hit) begin
            wb_dat_r = r_bank[word_sel];
        end
    end

endmodule

// File: src/vec_unit.sv
`timescale 1ns/1ps

module vec_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    // Host Wishbone port
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [vec_pkg::WB_AW-1:0] wb_adr,
    input  logic [vec_pkg::WB_DW-1:0] wb_dat_w,
    output logic [vec_pkg::WB_DW-1:0] wb_dat_r,
    output logic                      wb_ack
);

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    // Run control
    logic                           start_req;
    vec_pkg::vec_op_e               req_op;
    vec_pkg::vec_op_e               run_op;
    logic                           busy;
    logic                           done;
    logic                           run_start;
    // Tile indexing
    logic                           cnt_clr;
    logic                           cnt_en;
    logic [vec_pkg::TILE_IDX_W-1:0] tile_idx;
    logic                           last;
    // Datapath in and out
    logic                           issue_valid;
    logic [vec_pkg::TILE_BITS-1:0]  a_tile;
    logic [vec_pkg::TILE_BITS-1:0]  b_tile;
    logic                           out_valid;
    logic [vec_pkg::TILE_IDX_W-1:0] out_tile;
    logic [vec_pkg::TILE_BITS-1:0]  result_tile;
    logic                           out_sat;

    // Bus slave and tile storage
    vec_regs u_vec_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .start_req   (start_req),
        .req_op      (req_op),
        .busy        (busy),
        .done        (done),
        .run_start   (run_start),
        .tile_idx    (tile_idx),
        .a_tile      (a_tile),
        .b_tile      (b_tile),
        .out_valid   (out_valid),
        .out_tile    (out_tile),
        .result_tile (result_tile),
        .out_sat     (out_sat)
    );

    // Run FSM
    vec_ctrl u_vec_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req   (start_req),
        .req_op      (req_op),
        .last        (last),
        .cnt_clr     (cnt_clr),
        .cnt_en      (cnt_en),
        .issue_valid (issue_valid),
        .run_op      (run_op),
        .busy        (busy),
        .done        (done),
        .run_start   (run_start)
    );

    tile_counter u_tile_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .cnt_clr  (cnt_clr),
        .cnt_en   (cnt_en),
        .tile_idx (tile_idx),
        .last     (last)
    );

    // Tile index doubles as the result tag
    vector_add u_vector_add (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (issue_valid),
        .in_tile     (tile_idx),
        .op          (run_op),
        .a_tile      (a_tile),
        .b_tile      (b_tile),
        .out_valid   (out_valid),
        .out_tile    (out_tile),
        .result_tile (result_tile),
        .out_sat     (out_sat)
    );

endmodule

// File: src/vector_add.sv
`timescale 1ns/1ps

module vector_add (
    input  logic                           clk,
    input  logic                           rst_n,
    // Issued tile
    input  logic                           in_valid,
    input  logic [vec_pkg::TILE_IDX_W-1:0] in_tile,
    input  vec_pkg::vec_op_e               op,
    input  logic [vec_pkg::TILE_BITS-1:0]  a_tile,
    input  logic [vec_pkg::TILE_BITS-1:0]  b_tile,
    // Registered result, one cycle later
    output logic                           out_valid,
    output logic [vec_pkg::TILE_IDX_W-1:0] out_tile,
    output logic [vec_pkg::TILE_BITS-1:0]  result_tile,
    output logic                           out_sat
);

    logic [vec_pkg::TILE_BITS-1:0] lane_res;
    logic [vec_pkg::TILING-1:0]    lane_clip;

    ////////////////////////////////////////
    // Saturating lanes
    ////////////////////////////////////////

    for (genvar i = 0; i < vec_pkg::TILING; i++) begin : g_lane
        logic [vec_pkg::CELL_WIDTH:0] a_ext;
        logic [vec_pkg::CELL_WIDTH:0] b_ext;
        logic [vec_pkg::CELL_WIDTH:0] sum;

        // One guard bit by sign extension
        assign a_ext = {a_tile[i*vec_pkg::CELL_WIDTH + vec_pkg::CELL_WIDTH-1],
                        a_tile[i*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH]};
        assign b_ext = {b_tile[i*vec_pkg::CELL_WIDTH + vec_pkg::CELL_WIDTH-1],
                        b_tile[i*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH]};
        assign sum = (op == vec_pkg::OP_SUB) ? a_ext - b_ext : a_ext + b_ext;

        // Guard and sign bit disagree on overflow
        assign lane_clip[i] = sum[vec_pkg::CELL_WIDTH] != sum[vec_pkg::CELL_WIDTH-1];

        // Clamp to -128 or 127 by the true sign
        always_comb begin
            if (!lane_clip[i]) begin
                lane_res[i*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH] =
                    sum[vec_pkg::CELL_WIDTH-1:0];
            end else if (sum[vec_pkg::CELL_WIDTH]) begin
                lane_res[i*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH] =
                    {1'b1, {(vec_pkg::CELL_WIDTH-1){1'b0}}};
            end else begin
                lane_res[i*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH] =
                    {1'b0, {(vec_pkg::CELL_WIDTH-1){1'b1}}};
            end
        end
    end

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Tag, data and clip flag move with the valid bit
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_tile    <= in_tile;
            result_tile <= lane_res;
            out_sat     <= |lane_clip;
        end
    end

endmodule

// File: test/tb_vec_unit.sv
`timescale 1ns/1ps

module tb_vec_unit;

    // 20 runs of 32 accesses at 3 cycles plus polling, doubled
    localparam int TIMEOUT_CYCLES = 2 * 20 * (32 * 3 + 20);

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    int          cycles;
    int unsigned seed_ret;
    logic [31:0] rd_word;

    // Reference model state
    logic signed [7:0] a_mod [16];
    logic signed [7:0] b_mod [16];
    logic [31:0]       exp_r [4];
    logic              exp_sat;

    vec_unit u_vec_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #50 clk = ~clk;

    // Watchdog on total run length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test sequence did not finish", cycles);
            $display("Checks failed");
            $fatal(1, "run stopped by watchdog");
        end
    end

    ////////////////////////////////////////
    // Checking and bus tasks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Hold stb until ack, then drop it for one cycle
    task automatic wb_access(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    // Poll STATUS until the run reports done
    task automatic wait_done(output logic [31:0] st);
        do begin
            wb_read(vec_pkg::ADR_STATUS, st);
        end while (!st[vec_pkg::STAT_DONE_BIT]);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Mode 0 full range, 1 small values, 2 full range with forced clipping
    task automatic randomize_operands(input int mode);
        for (int i = 0; i < 16; i++) begin
            if (mode == 1) begin
                a_mod[i] = 8'(int'($urandom_range(0, 63)) - 32);
                b_mod[i] = 8'(int'($urandom_range(0, 63)) - 32);
            end else begin
                a_mod[i] = 8'($urandom);
                b_mod[i] = 8'($urandom);
            end
        end
        if (mode == 2) begin
            // -128 - 127 and 127 - (-127) clip on subtract
            a_mod[0] = -8'sd128;
            b_mod[0] = 8'sd127;
            a_mod[1] = 8'sd127;
            b_mod[1] = -8'sd127;
            // 127 + 127 and -128 + -128 clip on add
            a_mod[2] = 8'sd127;
            b_mod[2] = 8'sd127;
            a_mod[3] = -8'sd128;
            b_mod[3] = -8'sd128;
        end
    endtask

    function automatic logic [31:0] pack_tile(input int t, input logic use_b);
        logic [31:0] w;
        for (int e = 0; e < 4; e++) begin
            w[e*8 +: 8] = use_b ? b_mod[t*4 + e] : a_mod[t*4 + e];
        end
        return w;
    endfunction

    // Exact integer result, then clamp to -128..127
    task automatic compute_expected(input logic sub);
        int s;
        exp_sat = 1'b0;
        for (int i = 0; i < 16; i++) begin
            s = sub ? int'(a_mod[i]) - int'(b_mod[i]) : int'(a_mod[i]) + int'(b_mod[i]);
            if (s > 127) begin
                s = 127;
                exp_sat = 1'b1;
            end else if (s < -128) begin
                s = -128;
                exp_sat = 1'b1;
            end
            exp_r[i/4][(i%4)*8 +: 8] = s[7:0];
        end
    endtask

    ////////////////////////////////////////
    // One run with optional busy-time access
    ////////////////////////////////////////

    // Intrude 1 reads STATUS, 2 writes A, 3 writes B, 4 restarts
    task automatic run_vector(input logic sub, input int intrude);
        logic [31:0] rd;
        for (int t = 0; t < 4; t++) begin
            wb_write(vec_pkg::ADR_A_BASE + 4'(t), pack_tile(t, 1'b0));
            wb_write(vec_pkg::ADR_B_BASE + 4'(t), pack_tile(t, 1'b1));
        end
        compute_expected(sub);
        wb_write(vec_pkg::ADR_CTRL, {30'd0, sub, 1'b1});
        case (intrude)
            1: begin
                wb_read(vec_pkg::ADR_STATUS, rd);
                check_value("status.busy", 32'd1, 32'(rd[vec_pkg::STAT_BUSY_BIT]));
            end
            2: wb_write(vec_pkg::ADR_A_BASE + 4'($urandom_range(0, 3)), $urandom);
            3: wb_write(vec_pkg::ADR_B_BASE + 4'($urandom_range(0, 3)), $urandom);
            4: wb_write(vec_pkg::ADR_CTRL, {30'd0, !sub, 1'b1});
            default: ;
        endcase
        wait_done(rd);
        check_value("status", {29'd0, exp_sat, 2'b10}, rd);
        for (int t = 0; t < 4; t++) begin
            wb_read(vec_pkg::ADR_R_BASE + 4'(t), rd);
            check_value($sformatf("r[%0d]", t), exp_r[t], rd);
        end
        // Operands must survive the busy-time writes
        if (intrude != 0) begin
            for (int t = 0; t < 4; t++) begin
                wb_read(vec_pkg::ADR_A_BASE + 4'(t), rd);
                check_value($sformatf("a[%0d]", t), pack_tile(t, 1'b0), rd);
                wb_read(vec_pkg::ADR_B_BASE + 4'(t), rd);
                check_value($sformatf("b[%0d]", t), pack_tile(t, 1'b1), rd);
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cycles   = 0;
        seed_ret = $urandom(32'hf5a3);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        wb_read(vec_pkg::ADR_STATUS, rd_word);
        check_value("status", 32'd0, rd_word);
        for (int t = 0; t < 4; t++) begin
            wb_read(vec_pkg::ADR_R_BASE + 4'(t), rd_word);
            check_value($sformatf("r[%0d]", t), 32'd0, rd_word);
        end

        // Random add and subtract runs, first of each forced to clip
        for (int n = 0; n < 10; n++) begin
            randomize_operands(n == 0 ? 2 : 0);
            run_vector(1'b0, 0);
        end
        for (int n = 0; n < 10; n++) begin
            randomize_operands(n == 0 ? 2 : 0);
            run_vector(1'b1, 0);
        end

        // Host accesses while busy
        for (int k = 1; k <= 4; k++) begin
            randomize_operands(0);
            run_vector(1'($urandom), k);
        end

        // Sticky flag must clear on the next start
        randomize_operands(2);
        run_vector(1'b0, 0);
        randomize_operands(1);
        run_vector(1'b0, 0);
        wb_read(vec_pkg::ADR_STATUS, rd_word);
        check_value("status.sat", 32'd0, 32'(rd_word[vec_pkg::STAT_SAT_BIT]));

        // Unmapped reads and ignored R write
        wb_read(4'd0, rd_word);
        check_value("adr0", 32'd0, rd_word);
        wb_read(4'd2, rd_word);
        check_value("adr2", 32'd0, rd_word);
        wb_read(4'd3, rd_word);
        check_value("adr3", 32'd0, rd_word);
        wb_write(vec_pkg::ADR_R_BASE, $urandom);
        wb_read(vec_pkg::ADR_R_BASE, rd_word);
        check_value("r[0]", exp_r[0], rd_word);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: test/vec_unit_sva.sv
`timescale 1ns/1ps

module vec_unit_sva (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic busy,
    input logic done
);

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////

    // Single-cycle ack per strobe
    a_ack_single : assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    // Ack only inside an active cycle
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without cyc and stb");

    ////////////////////////////////////////
    // Run timing
    ////////////////////////////////////////

    // Four issue cycles plus one drain
    a_busy_len : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> busy [*5] ##1 !busy)
        else $error("busy not high for exactly 5 cycles");

    a_busy_done : assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else $error("busy and done high together");

endmodule

// Internal run status comes from the top level scope
bind vec_unit vec_unit_sva u_vec_unit_sva (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .busy   (busy),
    .done   (done)
);

// File: vec_unit.f
src/vec_pkg.sv
src/tile_counter.sv
src/vector_add.sv
src/vec_ctrl.sv
src/vec_regs.sv
src/vec_unit.sv
test/vec_unit_sva.sv
test/tb_vec_unit.sv
